//--- verilog/tl_pkg.sv
`default_nettype none

package tl_pkg;

	////////////////////
	// Channel widths
	////////////////////

	localparam int TL_ADDR_W   = 64;            // Byte address
	localparam int TL_DATA_W   = 64;            // One beat, one word
	localparam int TL_MASK_W   = TL_DATA_W / 8; // One bit per data byte
	localparam int TL_SIZE_W   = 8;             // log2 of bytes moved
	localparam int TL_SOURCE_W = 3;             // Transaction ID, echoed on D
	localparam int TL_OPCODE_W = 3;

	////////////////////
	// Opcodes
	////////////////////

	// Full A channel opcode space of which only 0, 1 and 4 are served
	typedef enum logic [TL_OPCODE_W-1:0] {
		PUT_FULL_DATA    = 3'd0,
		PUT_PARTIAL_DATA = 3'd1,
		ARITHMETIC_DATA  = 3'd2, // Atomic, unsupported
		LOGICAL_DATA     = 3'd3, // Atomic, unsupported
		GET              = 3'd4,
		INTENT           = 3'd5, // Hint, unsupported
		ACQUIRE_BLOCK    = 3'd6, // TL-C only
		ACQUIRE_PERM     = 3'd7  // TL-C only
	} tl_a_opcode_e;

	// D channel responses of a UL slave
	typedef enum logic [TL_OPCODE_W-1:0] {
		ACCESS_ACK      = 3'd0, // Dataless ack, Put or error
		ACCESS_ACK_DATA = 3'd1  // Ack with read data
	} tl_d_opcode_e;

endpackage

`default_nettype wire

//--- verilog/slave_cfg_pkg.sv
`default_nettype none

package slave_cfg_pkg;

	////////////////////
	// RAM geometry
	////////////////////

	localparam int MEM_DEPTH     = 512; // Words of 64 bits
	localparam int MEM_INDEX_W   = 9;   // log2 of MEM_DEPTH

	////////////////////
	// Address decode
	////////////////////

	localparam int WORD_OFFSET_W = 3;   // Byte offset inside a word, ignored
	// Lowest address bit that must be clear for the 4 KiB window
	localparam int MEM_ADDR_TOP  = WORD_OFFSET_W + MEM_INDEX_W;

endpackage

`default_nettype wire

//--- verilog/tl_slave_ifs.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////
// Buffered A request
////////////////////

interface a_req_if;
	import tl_pkg::*;

	logic                   valid;   // Buffer holds a request
	logic                   take;    // Control unit can accept now
	tl_a_opcode_e           opcode;
	logic [TL_ADDR_W-1:0]   address;
	logic [TL_SIZE_W-1:0]   size;
	logic [TL_MASK_W-1:0]   mask;
	logic [TL_DATA_W-1:0]   data;
	logic [TL_SOURCE_W-1:0] source;

	modport src (output valid, opcode, address, size, mask, data, source, input take);
	modport dst (input valid, opcode, address, size, mask, data, source, output take);
endinterface

////////////////////
// RAM port
////////////////////

interface mem_if;
	import tl_pkg::*;
	import slave_cfg_pkg::*;

	logic                   wen;
	logic [MEM_INDEX_W-1:0] index;  // Shared by read and write
	logic [TL_DATA_W-1:0]   wdata;
	logic [TL_MASK_W-1:0]   wmask;  // Byte enables
	logic [TL_DATA_W-1:0]   rdata;  // Word at last cycle's index

	modport master (output wen, index, wdata, wmask, input rdata);
	modport slave (input wen, index, wdata, wmask, output rdata);
endinterface

////////////////////
// D response
////////////////////

interface d_rsp_if;
	import tl_pkg::*;

	logic                   load;   // Capture response this edge
	logic                   free;   // D register empty or draining
	tl_d_opcode_e           opcode;
	logic [TL_SIZE_W-1:0]   size;
	logic [TL_SOURCE_W-1:0] source;
	logic [TL_DATA_W-1:0]   data;
	logic                   error;

	modport src (output load, opcode, size, source, data, error, input free);
	modport dst (input load, opcode, size, source, data, error, output free);
endinterface

`default_nettype wire

//--- verilog/tl_a_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tl_a_capture (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           a_valid,
	input  logic [tl_pkg::TL_OPCODE_W-1:0] a_opcode,
	input  logic [tl_pkg::TL_ADDR_W-1:0]   a_address,
	input  logic [tl_pkg::TL_SIZE_W-1:0]   a_size,
	input  logic [tl_pkg::TL_MASK_W-1:0]   a_mask,
	input  logic [tl_pkg::TL_DATA_W-1:0]   a_data,
	input  logic [tl_pkg::TL_SOURCE_W-1:0] a_source,
	output logic                           a_ready,
	a_req_if.src                           req
);
	import tl_pkg::*;

	logic a_fire; // A handshake this edge

	assign a_ready = ~req.valid; // Accept only into an empty slot
	assign a_fire  = a_valid & a_ready;

	// Occupancy flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			req.valid <= 1'b0;
		end else if (a_fire) begin
			req.valid <= 1'b1;
		end else if (req.take) begin
			req.valid <= 1'b0; // Control unit took it
		end
	end

	// Payload held while valid
	always_ff @(posedge clk) begin
		if (a_fire) begin
			req.opcode  <= tl_a_opcode_e'(a_opcode);
			req.address <= a_address;
			req.size    <= a_size;
			req.mask    <= a_mask;
			req.data    <= a_data;
			req.source  <= a_source;
		end
	end

endmodule

`default_nettype wire

//--- verilog/tl_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tl_access_ctrl (
	input  logic   clk,
	input  logic   rst,
	a_req_if.dst   req,
	mem_if.master  mem,
	d_rsp_if.src   rsp
);
	import tl_pkg::*;
	import slave_cfg_pkg::*;

	typedef enum logic {
		CTRL_IDLE,
		CTRL_READ_WAIT // RAM read in flight
	} ctrl_state_e;

	ctrl_state_e            state;
	logic                   accept;    // Request transfers this edge
	logic                   is_put;
	logic                   is_get;
	logic                   in_range;
	logic                   req_ok;    // Supported and in range
	logic                   rd_go;     // Request needs the RAM read path
	logic [TL_SIZE_W-1:0]   rd_size;   // Echo fields kept across the read
	logic [TL_SOURCE_W-1:0] rd_source;

	////////////////////
	// Decode
	////////////////////

	assign is_put   = (req.opcode == PUT_FULL_DATA) | (req.opcode == PUT_PARTIAL_DATA);
	assign is_get   = (req.opcode == GET);
	assign in_range = ~|req.address[TL_ADDR_W-1:MEM_ADDR_TOP]; // Nothing above bit 11
	assign req_ok   = (is_put | is_get) & in_range;
	assign rd_go    = is_get & in_range;

	assign req.take = (state == CTRL_IDLE) & rsp.free;
	assign accept   = req.valid & req.take;

	////////////////////
	// RAM drive
	////////////////////

	assign mem.index = req.address[MEM_ADDR_TOP-1:WORD_OFFSET_W]; // Word index, bits 11:3
	assign mem.wdata = req.data;
	assign mem.wmask = (req.opcode == PUT_FULL_DATA) ? {TL_MASK_W{1'b1}} : req.mask;
	assign mem.wen   = accept & is_put & in_range; // Same edge as the ack load

	// Read sequencer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= CTRL_IDLE;
		end else begin
			case (state)
				CTRL_IDLE:      if (accept && rd_go) state <= CTRL_READ_WAIT;
				CTRL_READ_WAIT: state <= CTRL_IDLE; // rdata valid now
				default:        state <= CTRL_IDLE;
			endcase
		end
	end

	// Buffer may refill during the read, so keep the echo fields
	always_ff @(posedge clk) begin
		if (accept && rd_go) begin
			rd_size   <= req.size;
			rd_source <= req.source;
		end
	end

	////////////////////
	// Response build
	////////////////////

	// D is empty after a Get take, so READ_WAIT always finds it free
	assign rsp.load = (accept & ~rd_go) | (state == CTRL_READ_WAIT);

	always_comb begin
		if (state == CTRL_READ_WAIT) begin
			rsp.opcode = ACCESS_ACK_DATA;
			rsp.size   = rd_size;
			rsp.source = rd_source;
			rsp.data   = mem.rdata;
			rsp.error  = 1'b0;
		end else begin
			rsp.opcode = is_get ? ACCESS_ACK_DATA : ACCESS_ACK;
			rsp.size   = req.size;   // Echo
			rsp.source = req.source; // Echo
			rsp.data   = '0;         // Dataless or out-of-range Get
			rsp.error  = ~req_ok;
		end
	end

endmodule

`default_nettype wire

//--- verilog/tl_d_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tl_d_channel (
	input  logic                           clk,
	input  logic                           rst,
	d_rsp_if.dst                           rsp,
	input  logic                           d_ready,
	output logic                           d_valid,
	output logic [tl_pkg::TL_OPCODE_W-1:0] d_opcode,
	output logic [tl_pkg::TL_SIZE_W-1:0]   d_size,
	output logic [tl_pkg::TL_SOURCE_W-1:0] d_source,
	output logic [tl_pkg::TL_DATA_W-1:0]   d_data,
	output logic                           d_error
);

	// Empty, or the master takes the held response this edge
	assign rsp.free = ~d_valid | d_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			d_valid <= 1'b0;
		end else if (rsp.load) begin
			d_valid <= 1'b1; // Back to back on a draining edge
		end else if (d_ready) begin
			d_valid <= 1'b0;
		end
	end

	// Fields change only on load, so they hold under back-pressure
	always_ff @(posedge clk) begin
		if (rsp.load) begin
			d_opcode <= rsp.opcode;
			d_size   <= rsp.size;
			d_source <= rsp.source;
			d_data   <= rsp.data;
			d_error  <= rsp.error;
		end
	end

endmodule

`default_nettype wire

//--- verilog/tl_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tl_ram (
	input  logic  clk,
	mem_if.slave  mem
);
	import tl_pkg::*;
	import slave_cfg_pkg::*;

	logic [TL_DATA_W-1:0] ram [MEM_DEPTH]; // Contents undefined until written

	////////////////////
	// Byte write, registered read
	////////////////////

	always_ff @(posedge clk) begin
		if (mem.wen) begin
			for (int b = 0; b < TL_MASK_W; b++) begin
				if (mem.wmask[b]) begin
					ram[mem.index][b*8 +: 8] <= mem.wdata[b*8 +: 8];
				end
			end
		end
		mem.rdata <= ram[mem.index]; // One cycle latency with old data on a same-edge write
	end

endmodule

`default_nettype wire

//--- verilog/tl_ul_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tl_ul_slave (
	input  logic                           clk,
	input  logic                           rst,
	// A channel from the master
	input  logic                           a_valid,
	input  logic [tl_pkg::TL_OPCODE_W-1:0] a_opcode,
	input  logic [tl_pkg::TL_ADDR_W-1:0]   a_address,
	input  logic [tl_pkg::TL_SIZE_W-1:0]   a_size,
	input  logic [tl_pkg::TL_MASK_W-1:0]   a_mask,
	input  logic [tl_pkg::TL_DATA_W-1:0]   a_data,
	input  logic [tl_pkg::TL_SOURCE_W-1:0] a_source,
	output logic                           a_ready,
	// D channel to the master
	input  logic                           d_ready,
	output logic                           d_valid,
	output logic [tl_pkg::TL_OPCODE_W-1:0] d_opcode,
	output logic [tl_pkg::TL_SIZE_W-1:0]   d_size,
	output logic [tl_pkg::TL_SOURCE_W-1:0] d_source,
	output logic [tl_pkg::TL_DATA_W-1:0]   d_data,
	output logic                           d_error
);

	a_req_if a_req ();  // Buffer to control
	mem_if   mem_bus ();  // Control to RAM
	d_rsp_if d_rsp ();  // Control to D register

	tl_a_capture u_a_capture (
		.clk       (clk),
		.rst       (rst),
		.a_valid   (a_valid),
		.a_opcode  (a_opcode),
		.a_address (a_address),
		.a_size    (a_size),
		.a_mask    (a_mask),
		.a_data    (a_data),
		.a_source  (a_source),
		.a_ready   (a_ready),
		.req       (a_req.src)
	);

	tl_access_ctrl u_access_ctrl (
		.clk (clk),
		.rst (rst),
		.req (a_req.dst),
		.mem (mem_bus.master),
		.rsp (d_rsp.src)
	);

	tl_ram u_ram (
		.clk (clk),
		.mem (mem_bus.slave)
	);

	tl_d_channel u_d_channel (
		.clk      (clk),
		.rst      (rst),
		.rsp      (d_rsp.dst),
		.d_ready  (d_ready),
		.d_valid  (d_valid),
		.d_opcode (d_opcode),
		.d_size   (d_size),
		.d_source (d_source),
		.d_data   (d_data),
		.d_error  (d_error)
	);

endmodule

`default_nettype wire

//--- sim/tl_ul_slave_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tl_ul_slave_assertions (
	input logic                           clk,
	input logic                           rst,
	input logic                           a_ready,
	input logic                           a_held,   // A buffer occupied
	input logic                           d_ready,
	input logic                           d_valid,
	input logic [tl_pkg::TL_OPCODE_W-1:0] d_opcode,
	input logic [tl_pkg::TL_SIZE_W-1:0]   d_size,
	input logic [tl_pkg::TL_SOURCE_W-1:0] d_source,
	input logic [tl_pkg::TL_DATA_W-1:0]   d_data,
	input logic                           d_error
);

	int fail_rst    = 0; // Failure counts per property
	int fail_stable = 0;
	int fail_ready  = 0;

	a_rst_quiet: assert property (@(posedge clk) rst |-> !d_valid)
		else begin
			fail_rst = fail_rst + 1;
			$error("d_valid high during reset");
		end

	// Held response must not move
	a_d_stable: assert property (@(posedge clk) disable iff (rst)
		(d_valid && !d_ready) |=> (d_valid && $stable(d_opcode) && $stable(d_size)
			&& $stable(d_source) && $stable(d_data) && $stable(d_error)))
		else begin
			fail_stable = fail_stable + 1;
			$error("D channel changed under back-pressure");
		end

	// Stalled D keeps the buffered request in place
	a_full_stall: assert property (@(posedge clk) disable iff (rst)
		(d_valid && !d_ready && a_held) |=> !a_ready)
		else begin
			fail_ready = fail_ready + 1;
			$error("a_ready rose while both slots were full");
		end

endmodule

bind tl_ul_slave tl_ul_slave_assertions u_sva (
	.clk      (clk),
	.rst      (rst),
	.a_ready  (a_ready),
	.a_held   (a_req.valid),
	.d_ready  (d_ready),
	.d_valid  (d_valid),
	.d_opcode (d_opcode),
	.d_size   (d_size),
	.d_source (d_source),
	.d_data   (d_data),
	.d_error  (d_error)
);

`default_nettype wire

//--- sim/tb_tl_ul_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tl_ul_slave;
	import tl_pkg::*;
	import slave_cfg_pkg::*;

	localparam int TIMEOUT = 40; // Cycles allowed per wait

	logic                   clk;
	logic                   rst;
	logic                   a_valid;
	logic [TL_OPCODE_W-1:0] a_opcode;
	logic [TL_ADDR_W-1:0]   a_address;
	logic [TL_SIZE_W-1:0]   a_size;
	logic [TL_MASK_W-1:0]   a_mask;
	logic [TL_DATA_W-1:0]   a_data;
	logic [TL_SOURCE_W-1:0] a_source;
	logic                   a_ready;
	logic                   d_ready;
	logic                   d_valid;
	logic [TL_OPCODE_W-1:0] d_opcode;
	logic [TL_SIZE_W-1:0]   d_size;
	logic [TL_SOURCE_W-1:0] d_source;
	logic [TL_DATA_W-1:0]   d_data;
	logic                   d_error;

	logic [TL_DATA_W-1:0]   model [MEM_DEPTH]; // Reference memory
	logic [TL_ADDR_W-1:0]   known [8];         // Addresses written by the first test

	// Expected responses in issue order
	logic [TL_OPCODE_W-1:0] exp_op [$];
	logic [TL_SIZE_W-1:0]   exp_size [$];
	logic [TL_SOURCE_W-1:0] exp_src [$];
	logic [TL_DATA_W-1:0]   exp_data [$];
	logic                   exp_err [$];

	tl_ul_slave UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected)
			fail_run($sformatf("FAILED at %0d ns: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	function automatic logic [63:0] rand64();
		return {$urandom, $urandom};
	endfunction

	// Expected response with the model updated for in-range Puts
	task automatic predict(input logic [2:0] op, input logic [63:0] addr, input logic [7:0] mask,
			input logic [63:0] data, input logic [7:0] size, input logic [2:0] src);
		logic        ok;
		logic [63:0] word;
		int          b;
		ok   = (addr[63:12] == '0) && (op == PUT_FULL_DATA || op == PUT_PARTIAL_DATA || op == GET);
		word = model[addr[11:3]]; // Byte offset ignored
		if (ok && op != GET) begin
			for (b = 0; b < 8; b++)
				if (op == PUT_FULL_DATA || mask[b]) word[b*8 +: 8] = data[b*8 +: 8];
			model[addr[11:3]] = word;
		end
		exp_op.push_back(op == GET ? 3'd1 : 3'd0);
		exp_size.push_back(size);
		exp_src.push_back(src);
		exp_data.push_back((ok && op == GET) ? word : 64'd0); // Zero on a bad Get
		exp_err.push_back(!ok);
	endtask

	// A channel send that starts and ends just after a falling edge
	task automatic send_req(input logic [2:0] op, input logic [63:0] addr, input logic [7:0] mask,
			input logic [63:0] data);
		logic [31:0] r;
		int          n;
		r = $urandom;
		predict(op, addr, mask, data, {6'd0, r[1:0]}, r[4:2]);
		a_valid   = 1'b1;
		a_opcode  = op;
		a_address = addr;
		a_size    = {6'd0, r[1:0]};
		a_mask    = mask;
		a_data    = data;
		a_source  = r[4:2];
		n = 0;
		while (!a_ready) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) fail_run("Timeout: a_ready never went high for a request");
		end
		@(posedge clk); // Handshake edge
		@(negedge clk);
		a_valid = 1'b0;
	endtask

	// D channel receive checked against the oldest expected response
	task automatic take_rsp();
		int n;
		if (exp_op.size() == 0) fail_run("Response wait with no request outstanding");
		d_ready = 1'b1;
		n = 0;
		while (!d_valid) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) fail_run("Timeout: d_valid never went high for a response");
		end
		check("d_opcode", 64'(d_opcode), 64'(exp_op[0]));
		check("d_size", 64'(d_size), 64'(exp_size[0]));
		check("d_source", 64'(d_source), 64'(exp_src[0]));
		check("d_error", 64'(d_error), 64'(exp_err[0]));
		if (exp_op[0] == 3'd1) check("d_data", d_data, exp_data[0]); // Data only on AccessAckData
		void'(exp_op.pop_front());
		void'(exp_size.pop_front());
		void'(exp_src.pop_front());
		void'(exp_data.pop_front());
		void'(exp_err.pop_front());
		@(posedge clk);
		@(negedge clk);
		d_ready = 1'b0;
	endtask

	task automatic access(input logic [2:0] op, input logic [63:0] addr, input logic [7:0] mask,
			input logic [63:0] data);
		send_req(op, addr, mask, data);
		take_rsp();
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic test_put_full_get();
		logic [31:0] r;
		int          i;
		for (i = 0; i < 8; i++) begin
			r = $urandom;
			known[i] = {52'd0, r[8:0], r[11:9]}; // Random word, random byte offset
			access(PUT_FULL_DATA, known[i], 8'hFF, rand64());
		end
		for (i = 0; i < 8; i++) access(GET, known[i], 8'h00, 64'd0);
	endtask

	task automatic test_put_partial();
		logic [31:0] r;
		int          i;
		for (i = 0; i < 8; i++) begin
			r = $urandom;
			access(PUT_PARTIAL_DATA, known[i], r[7:0], rand64());
			access(GET, known[i], 8'h00, 64'd0);
		end
	endtask

	task automatic test_out_of_range();
		logic [31:0] r;
		logic [63:0] bad;
		int          i;
		int          bit_pos;
		for (i = 0; i < 4; i++) begin
			r = $urandom;
			bit_pos = 12 + int'(r[5:0]) % 52; // Somewhere in bits 63:12
			bad = known[i] | (64'd1 << bit_pos);
			access(PUT_FULL_DATA, bad, 8'hFF, rand64());
			access(GET, bad, 8'h00, 64'd0);
			access(GET, known[i], 8'h00, 64'd0); // Alias untouched
		end
	endtask

	task automatic test_unsupported();
		logic [3:0] op;
		for (op = 4'd0; op < 4'd8; op++) begin
			if (op == 4'd0 || op == 4'd1 || op == 4'd4) continue;
			access(op[2:0], known[op[2:0]], 8'hFF, rand64());
			access(GET, known[op[2:0]], 8'h00, 64'd0);
		end
	endtask

	// Two requests against a stalled D channel
	task automatic test_backpressure();
		logic [31:0] r;
		logic [63:0] snap_data;
		logic [2:0]  snap_src;
		int          i;
		d_ready = 1'b0;
		send_req(PUT_FULL_DATA, known[5], 8'hFF, rand64());
		send_req(GET, known[5], 8'h00, 64'd0);
		check("d_valid", 64'(d_valid), 64'd1);
		check("a_ready", 64'(a_ready), 64'd0); // Both slots full
		snap_data = d_data;
		snap_src  = d_source;
		r = $urandom;
		for (i = 0; i < 2 + int'(r[2:0]); i++) begin
			@(negedge clk);
			check("d_valid", 64'(d_valid), 64'd1);
			check("d_source", 64'(d_source), 64'(snap_src));
			check("d_data", d_data, snap_data);
			check("a_ready", 64'(a_ready), 64'd0);
		end
		take_rsp(); // Put ack first
		take_rsp(); // Then the Get with the new word
	endtask

	initial begin
		void'($urandom(38986));
		rst       = 1'b1;
		a_valid   = 1'b0;
		a_opcode  = '0;
		a_address = '0;
		a_size    = '0;
		a_mask    = '0;
		a_data    = '0;
		a_source  = '0;
		d_ready   = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_put_full_get();
		test_put_partial();
		test_out_of_range();
		test_unsupported();
		test_backpressure();
		repeat (2) @(negedge clk);
		if (UUT.u_sva.fail_rst + UUT.u_sva.fail_stable + UUT.u_sva.fail_ready != 0) begin
			fail_run("Protocol assertions failed during the run");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tl_ul_slave.f
verilog/tl_pkg.sv
verilog/slave_cfg_pkg.sv
verilog/tl_slave_ifs.sv
verilog/tl_a_capture.sv
verilog/tl_access_ctrl.sv
verilog/tl_d_channel.sv
verilog/tl_ram.sv
verilog/tl_ul_slave.sv
sim/tl_ul_slave_assertions.sv
sim/tb_tl_ul_slave.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tl_ul_slave.f \
	--top-module tb_tl_ul_slave -o tb_sim \
	&& ./obj_dir/tb_sim 2>&1 | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
